//--- common/io_pkg.sv
`default_nettype none

package io_pkg;

  // Bus write request, one per cycle while en is set.
  typedef struct packed {
    logic        en;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
  } io_wr_t;

  typedef struct packed {
    logic        en;
    logic [31:0] addr;
  } io_rd_req_t;

  // Combinational read result of one peripheral.
  typedef struct packed {
    logic        hit;
    logic [31:0] data;
  } io_rd_rsp_t;

  localparam logic [31:0] IO_LED_ADDR         = 32'h8000_0000;
  localparam logic [31:0] IO_GPIO_ADDR        = 32'h8000_0004;
  localparam logic [31:0] IO_UART_TX_ADDR     = 32'h8000_0008;
  localparam logic [31:0] IO_UART_STATUS_ADDR = 32'h8000_000C;

  localparam int UART_BUSY_BIT    = 0;
  localparam int UART_FULL_BIT    = 1;
  localparam int UART_OVERRUN_BIT = 2;

  localparam int CLOCK_FREQ     = 100_000_000;
  localparam int BAUD_RATE      = 115_200;
  localparam int CLKS_PER_BIT   = CLOCK_FREQ / BAUD_RATE;
  localparam int UART_CNT_WIDTH = $clog2(CLKS_PER_BIT); // Baud counter width.

  localparam int LED_WIDTH  = 4;
  localparam int GPIO_WIDTH = 8;

endpackage

`default_nettype wire

//--- uart/uart_io.sv
`timescale 1ns/1ps
`default_nettype none

module uart_io (
  input  wire                 clk,
  input  wire                 reset,
  input  io_pkg::io_wr_t      io_wr,
  input  io_pkg::io_rd_req_t  io_rd_req,
  output io_pkg::io_rd_rsp_t  rd_rsp,
  output logic                uart_tx
);
  import io_pkg::*;

  logic [7:0]                hold_data;
  logic                      hold_full;
  logic                      overrun;
  logic                      busy;
  logic [9:0]                shift_reg;
  logic [3:0]                bit_cnt;
  logic [UART_CNT_WIDTH-1:0] baud_cnt;

  logic data_wr;
  logic status_rd;
  logic bit_end;
  logic frame_end;
  logic take;
  logic accept;

  assign data_wr   = io_wr.en && io_wr.strb[0] && (io_wr.addr == IO_UART_TX_ADDR);
  assign status_rd = io_rd_req.en && (io_rd_req.addr == IO_UART_STATUS_ADDR);

  assign bit_end   = busy && (baud_cnt == UART_CNT_WIDTH'(CLKS_PER_BIT - 1));
  assign frame_end = bit_end && (bit_cnt == 4'd9); // Last cycle of the stop bit.

  // The shifter takes the next byte when idle, or straight at the end of a frame.
  assign take   = hold_full && (!busy || frame_end);
  assign accept = !hold_full || take; // A byte leaving frees the slot this cycle.

  // Byte waiting for the shifter.
  always_ff @(posedge clk) begin
    if (data_wr && accept) begin
      hold_data <= io_wr.data[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hold_full <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      if (data_wr && accept) begin
        hold_full <= 1'b1;
      end else if (take) begin
        hold_full <= 1'b0;
      end

      if (data_wr && !accept) begin
        overrun <= 1'b1; // Byte is dropped.
      end else if (status_rd) begin
        overrun <= 1'b0; // Status value was already sampled this cycle.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      shift_reg <= '1; // Line idles high.
      bit_cnt   <= '0;
      baud_cnt  <= '0;
    end else if (take) begin
      busy      <= 1'b1;
      shift_reg <= {1'b1, hold_data, 1'b0}; // Stop, data LSB first, start.
      bit_cnt   <= '0;
      baud_cnt  <= '0;
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt  <= '0;
        bit_cnt   <= bit_cnt + 4'd1;
        shift_reg <= {1'b1, shift_reg[9:1]};
        if (frame_end) begin
          busy <= 1'b0;
        end
      end else begin
        baud_cnt <= baud_cnt + UART_CNT_WIDTH'(1);
      end
    end
  end

  assign uart_tx = shift_reg[0];

  always_comb begin
    rd_rsp      = '0;
    rd_rsp.hit  = io_rd_req.en &&
                  ((io_rd_req.addr == IO_UART_TX_ADDR) ||
                   (io_rd_req.addr == IO_UART_STATUS_ADDR));
    if (status_rd) begin
      rd_rsp.data[UART_BUSY_BIT]    = busy;
      rd_rsp.data[UART_FULL_BIT]    = hold_full;
      rd_rsp.data[UART_OVERRUN_BIT] = overrun;
    end
    // The data address is write only and reads as zero.
  end

endmodule

`default_nettype wire

//--- source/gpio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
  input  wire                             clk,
  input  wire                             reset,
  input  io_pkg::io_wr_t                  io_wr,
  input  io_pkg::io_rd_req_t              io_rd_req,
  output io_pkg::io_rd_rsp_t              rd_rsp,
  input  wire  [io_pkg::GPIO_WIDTH-1:0]   gpio_in,
  output logic [io_pkg::LED_WIDTH-1:0]    led,
  output logic [io_pkg::GPIO_WIDTH-1:0]   gpio_out
);
  import io_pkg::*;

  logic [GPIO_WIDTH-1:0] gpio_meta;
  logic [GPIO_WIDTH-1:0] gpio_sync;
  logic                  lane0_wr;
  logic                  led_rd;
  logic                  gpio_rd;

  assign lane0_wr = io_wr.en && io_wr.strb[0]; // Both registers sit in byte lane 0.

  always_ff @(posedge clk) begin
    if (reset) begin
      led      <= '0;
      gpio_out <= '0;
    end else if (lane0_wr) begin
      if (io_wr.addr == IO_LED_ADDR) begin
        led <= io_wr.data[LED_WIDTH-1:0];
      end
      if (io_wr.addr == IO_GPIO_ADDR) begin
        gpio_out <= io_wr.data[GPIO_WIDTH-1:0];
      end
    end
  end

  // Two-flop synchronizer for the asynchronous pins.
  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= gpio_in;
      gpio_sync <= gpio_meta;
    end
  end

  assign led_rd  = io_rd_req.en && (io_rd_req.addr == IO_LED_ADDR);
  assign gpio_rd = io_rd_req.en && (io_rd_req.addr == IO_GPIO_ADDR);

  always_comb begin
    rd_rsp     = '0;
    rd_rsp.hit = led_rd || gpio_rd;
    if (led_rd) begin
      rd_rsp.data[LED_WIDTH-1:0] = led;
    end
    if (gpio_rd) begin
      rd_rsp.data[GPIO_WIDTH-1:0]          = gpio_out;
      rd_rsp.data[8 +: GPIO_WIDTH]         = gpio_sync; // Input in bits 15:8.
    end
  end

endmodule

`default_nettype wire

//--- source/io_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module io_read_mux (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 rd_en,
  input  io_pkg::io_rd_rsp_t  uart_rsp,
  input  io_pkg::io_rd_rsp_t  gpio_rsp,
  output logic [31:0]         io_rdata
);
  import io_pkg::*;

  logic [31:0] next_data;

  // Peripherals decode disjoint addresses, so at most one hit is set.
  always_comb begin
    next_data = '0;
    if (uart_rsp.hit) begin
      next_data = uart_rsp.data;
    end else if (gpio_rsp.hit) begin
      next_data = gpio_rsp.data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      io_rdata <= '0;
    end else if (rd_en) begin
      io_rdata <= next_data; // Unclaimed reads load zero.
    end
  end

endmodule

`default_nettype wire

//--- source/io_top.sv
`timescale 1ns/1ps
`default_nettype none

module io_top (
  input  wire                            clk,
  input  wire                            reset,
  input  io_pkg::io_wr_t                 io_wr,
  input  io_pkg::io_rd_req_t             io_rd_req,
  output logic [31:0]                    io_rdata,
  input  wire  [io_pkg::GPIO_WIDTH-1:0]  gpio_in,
  output logic [io_pkg::LED_WIDTH-1:0]   led,
  output logic [io_pkg::GPIO_WIDTH-1:0]  gpio_out,
  output logic                           uart_tx
);
  import io_pkg::*;

  io_rd_rsp_t uart_rsp;
  io_rd_rsp_t gpio_rsp;

  uart_io uart_io_i (
    .clk       (clk),
    .reset     (reset),
    .io_wr     (io_wr),
    .io_rd_req (io_rd_req),
    .rd_rsp    (uart_rsp),
    .uart_tx   (uart_tx)
  );

  gpio_regs gpio_regs_i (
    .clk       (clk),
    .reset     (reset),
    .io_wr     (io_wr),
    .io_rd_req (io_rd_req),
    .rd_rsp    (gpio_rsp),
    .gpio_in   (gpio_in),
    .led       (led),
    .gpio_out  (gpio_out)
  );

  // Registers the claimed read result one cycle after the strobe.
  io_read_mux io_read_mux_i (
    .clk       (clk),
    .reset     (reset),
    .rd_en     (io_rd_req.en),
    .uart_rsp  (uart_rsp),
    .gpio_rsp  (gpio_rsp),
    .io_rdata  (io_rdata)
  );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam realtime HALF_PERIOD = 2.0; // 4 ns period.

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- tests/io_top_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module io_top_assertions (
  input wire        clk,
  input wire        reset,
  input wire        rd_en,
  input wire [31:0] io_rdata,
  input wire        uart_tx,
  input wire        uart_busy,
  input wire        uart_hit,
  input wire        gpio_hit
);

  int unsigned error_count = 0; // Number of assertion failures so far.

  // The line stays at the idle level whenever the shifter is not sending.
  idle_line_high: assert property (@(posedge clk) disable iff (reset) !uart_busy |-> uart_tx)
    else begin
      error_count++;
      $error("uart_tx is low while the shifter is idle");
    end

  // Read data only moves as the result of a read strobe one cycle earlier.
  rdata_after_read: assert property (@(posedge clk) disable iff (reset)
    $changed(io_rdata) |-> $past(rd_en))
    else begin
      error_count++;
      $error("io_rdata changed without a read strobe in the previous cycle");
    end

  single_hit: assert property (@(posedge clk) disable iff (reset) !(uart_hit && gpio_hit))
    else begin
      error_count++;
      $error("Both peripherals claimed the same read");
    end

endmodule

bind io_top io_top_assertions io_top_assertions_i (
  .clk       (clk),
  .reset     (reset),
  .rd_en     (io_rd_req.en),
  .io_rdata  (io_rdata),
  .uart_tx   (uart_tx),
  .uart_busy (uart_io_i.busy),
  .uart_hit  (uart_rsp.hit),
  .gpio_hit  (gpio_rsp.hit)
);

`default_nettype wire

//--- tests/io_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module io_top_tb;
  import io_pkg::*;

  localparam int FRAME_CYCLES   = 10 * CLKS_PER_BIT;
  localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 2000;
  localparam logic [31:0] UNMAPPED_ADDR = 32'h8000_0010;
  localparam logic [31:0] STATUS_ALL = (32'd1 << UART_BUSY_BIT) | (32'd1 << UART_FULL_BIT) |
                                       (32'd1 << UART_OVERRUN_BIT);
  localparam logic [31:0] STATUS_BUSY_FULL = (32'd1 << UART_BUSY_BIT) |
                                             (32'd1 << UART_FULL_BIT);

  logic                  clk;
  logic                  reset;
  io_wr_t                io_wr;
  io_rd_req_t            io_rd_req;
  logic [31:0]           io_rdata;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [LED_WIDTH-1:0]  led;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic                  uart_tx;

  logic [31:0] lfsr_state = 32'he21c48ff;
  logic [7:0]  rx_q[$]; // Bytes rebuilt by the UART monitor, oldest first.
  string       test_name = "reset";
  int          cycle_count = 0;

  tb_clock tb_clock_i (.clk(clk));

  io_top io_top_i (
    .clk       (clk),
    .reset     (reset),
    .io_wr     (io_wr),
    .io_rd_req (io_rd_req),
    .io_rdata  (io_rdata),
    .gpio_in   (gpio_in),
    .led       (led),
    .gpio_out  (gpio_out),
    .uart_tx   (uart_tx)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  task automatic stop_on_failure(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_word(input string item, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      stop_on_failure($sformatf("[FAIL] %s %s expected 0x%08h actual 0x%08h",
                                test_name, item, exp, act));
    end
  endtask

  task automatic check_byte(input string item, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      stop_on_failure($sformatf("[FAIL] %s %s expected 0x%02h actual 0x%02h",
                                test_name, item, exp, act));
    end
  endtask

  task automatic check_bits(input string item, input logic [GPIO_WIDTH-1:0] exp,
                            input logic [GPIO_WIDTH-1:0] act);
    if (act !== exp) begin
      stop_on_failure($sformatf("[FAIL] %s %s expected 0x%02h actual 0x%02h",
                                test_name, item, exp, act));
    end
  endtask

  // Called 1 ns after a rising edge, and returns 1 ns after the edge that performs the write.
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    io_wr.en   = 1'b1;
    io_wr.addr = addr;
    io_wr.data = data;
    io_wr.strb = strb;
    @(posedge clk);
    #1;
    io_wr.en = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    io_rd_req.en   = 1'b1;
    io_rd_req.addr = addr;
    @(posedge clk);
    #1;
    io_rd_req.en = 1'b0;
    data = io_rdata; // Valid one cycle after the strobe.
  endtask

  task automatic wait_uart_idle();
    logic [31:0] status;
    status = '1;
    while (status[UART_BUSY_BIT] || status[UART_FULL_BIT]) begin
      bus_read(IO_UART_STATUS_ADDR, status);
    end
  endtask

  task automatic wait_rx_bytes(input int count);
    while (rx_q.size() < count) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic receive_frame(output logic [7:0] rx_byte);
    @(negedge uart_tx);
    repeat (CLKS_PER_BIT / 2) @(posedge clk);
    #1;
    if (uart_tx !== 1'b0) begin
      stop_on_failure($sformatf("UART start bit did not hold low in test %s", test_name));
    end
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
      rx_byte[i] = uart_tx; // LSB first.
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    #1;
    if (uart_tx !== 1'b1) begin
      stop_on_failure($sformatf("UART frame ended with a stop bit of 0 in test %s", test_name));
    end
  endtask

  initial begin
    logic [7:0] rx_byte;
    forever begin
      receive_frame(rx_byte);
      rx_q.push_back(rx_byte);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

  // The bound checker counts the failures of its assertions.
  always @(negedge clk) begin
    if (io_top_i.io_top_assertions_i.error_count != 0) begin
      stop_on_failure($sformatf("A concurrent assertion on io_top failed in test %s",
                                test_name));
    end
  end

  task automatic test_reset_state();
    logic [31:0] rdata;
    test_name = "reset_state";
    check_bits("uart_tx", 8'h01, 8'(uart_tx));
    check_bits("led", 8'h00, 8'(led));
    check_bits("gpio_out", 8'h00, gpio_out);
    check_word("rdata after reset", 32'h0, io_rdata);
    bus_read(IO_UART_STATUS_ADDR, rdata);
    check_word("status", 32'h0, rdata);
    bus_read(UNMAPPED_ADDR, rdata);
    check_word("unmapped read", 32'h0, rdata);
  endtask

  task automatic test_led_gpio(inout logic [LED_WIDTH-1:0] led_exp,
                               inout logic [GPIO_WIDTH-1:0] gpio_exp);
    logic [31:0] rdata;
    test_name = "led_gpio";
    for (int i = 0; i < 4; i++) begin
      led_exp  = LED_WIDTH'(take_bits(LED_WIDTH));
      gpio_exp = GPIO_WIDTH'(take_bits(GPIO_WIDTH));
      bus_write(IO_LED_ADDR, take_bits(28) << 4 | 32'(led_exp), 4'b0001);
      check_bits("led", 8'(led_exp), 8'(led));
      bus_write(IO_GPIO_ADDR, (take_bits(24) << 8) | 32'(gpio_exp), 4'b0001);
      check_bits("gpio_out", gpio_exp, gpio_out);
      bus_read(IO_LED_ADDR, rdata);
      check_word("led read", 32'(led_exp), rdata);
      bus_read(IO_GPIO_ADDR, rdata);
      check_word("gpio read", {16'h0, 8'h00, gpio_exp}, rdata); // gpio_in is still 0.
    end
    // Writes without byte lane 0 leave both registers alone.
    bus_write(IO_LED_ADDR, ~32'(led_exp), 4'b1110);
    bus_write(IO_GPIO_ADDR, ~32'(gpio_exp), 4'b1110);
    check_bits("led no lane 0", 8'(led_exp), 8'(led));
    check_bits("gpio_out no lane 0", gpio_exp, gpio_out);
  endtask

  task automatic test_gpio_input(input logic [GPIO_WIDTH-1:0] gpio_exp);
    logic [31:0] rdata;
    logic [7:0]  in_val;
    test_name = "gpio_input";
    in_val  = 8'(take_bits(8));
    gpio_in = in_val;
    repeat (3) @(posedge clk);
    #1;
    bus_read(IO_GPIO_ADDR, rdata);
    check_word("gpio read", {16'h0, in_val, gpio_exp}, rdata);
  endtask

  task automatic test_uart_frames();
    logic [7:0] tx_byte;
    test_name = "uart_frames";
    for (int i = 0; i < 3; i++) begin
      wait_uart_idle();
      tx_byte = 8'(take_bits(8));
      bus_write(IO_UART_TX_ADDR, {24'h0, tx_byte}, 4'b0001);
      wait_rx_bytes(1);
      check_byte($sformatf("byte %0d", i), tx_byte, rx_q.pop_front());
    end
  endtask

  task automatic test_overrun();
    logic [7:0]  tx_bytes[3];
    logic [31:0] rdata;
    test_name = "overrun";
    wait_uart_idle();
    for (int i = 0; i < 3; i++) begin
      tx_bytes[i] = 8'(take_bits(8));
    end
    for (int i = 0; i < 3; i++) begin
      bus_write(IO_UART_TX_ADDR, {24'h0, tx_bytes[i]}, 4'b0001);
    end
    bus_read(IO_UART_STATUS_ADDR, rdata);
    check_word("status after overrun", STATUS_ALL, rdata);
    bus_read(IO_UART_STATUS_ADDR, rdata);
    check_word("status second read", STATUS_BUSY_FULL, rdata);
    wait_rx_bytes(2);
    check_byte("first byte", tx_bytes[0], rx_q.pop_front());
    check_byte("second byte", tx_bytes[1], rx_q.pop_front());
    wait_uart_idle();
    bus_read(IO_UART_STATUS_ADDR, rdata);
    check_word("status when drained", 32'h0, rdata);
    if (rx_q.size() != 0) begin
      stop_on_failure("The dropped UART byte was sent anyway");
    end
  endtask

  task automatic test_unmapped(input logic [LED_WIDTH-1:0] led_exp,
                               input logic [GPIO_WIDTH-1:0] gpio_exp,
                               input logic [GPIO_WIDTH-1:0] in_exp);
    logic [31:0] rdata;
    logic [LED_WIDTH-1:0] led_val;
    test_name = "unmapped";
    led_val = LED_WIDTH'(take_bits(LED_WIDTH)) | 4'h1; // Nonzero, so the following read shows a change.
    bus_write(IO_LED_ADDR, 32'(led_val), 4'b0001);
    bus_write(UNMAPPED_ADDR, take_bits(32), 4'b1111);
    bus_write(32'h8000_0020, take_bits(32), 4'b1111);
    check_bits("led", 8'(led_val), 8'(led));
    check_bits("gpio_out", gpio_exp, gpio_out);
    check_bits("uart_tx", 8'h01, 8'(uart_tx));
    bus_read(IO_LED_ADDR, rdata);
    check_word("led read", 32'(led_val), rdata);
    bus_read(UNMAPPED_ADDR, rdata);
    check_word("unmapped read", 32'h0, rdata);
    bus_read(IO_GPIO_ADDR, rdata);
    check_word("gpio read", {16'h0, in_exp, gpio_exp}, rdata);
    bus_read(IO_UART_STATUS_ADDR, rdata);
    check_word("status", 32'h0, rdata);
  endtask

  initial begin
    logic [LED_WIDTH-1:0]  led_exp;
    logic [GPIO_WIDTH-1:0] gpio_exp;
    reset     = 1'b1;
    io_wr     = '0;
    io_rd_req = '0;
    gpio_in   = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_led_gpio(led_exp, gpio_exp);
    test_gpio_input(gpio_exp);
    test_uart_frames();
    test_overrun();
    test_unmapped(led_exp, gpio_exp, gpio_in);
    if (io_top_i.io_top_assertions_i.error_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_on_failure("A concurrent assertion on io_top failed");
    end
  end

endmodule

`default_nettype wire

//--- build.f
common/io_pkg.sv
uart/uart_io.sv
source/gpio_regs.sv
source/io_read_mux.sv
source/io_top.sv
tests/tb_clock.sv
tests/io_top_assertions.sv
tests/io_top_tb.sv

//--- Bender.yml
package:
  name: io_top

sources:
  - files:
      - common/io_pkg.sv
      - uart/uart_io.sv
      - source/gpio_regs.sv
      - source/io_read_mux.sv
      - source/io_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/io_top_assertions.sv
      - tests/io_top_tb.sv
